// ==== logic/soc_pkg.sv ====
package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;
  typedef logic [63:0] mtime_t;

  typedef enum logic [1:0] {
    grant_none,
    grant_inst,
    grant_data
  } grant_e;

  // regions run from base up to but not including top
  localparam addr_t tim0_base_addr = 32'h1000_0000;
  localparam addr_t tim0_top_addr = 32'h1000_1000;
  localparam addr_t tim1_base_addr = 32'h2000_0000;
  localparam addr_t tim1_top_addr = 32'h2000_1000;
  localparam addr_t clint_base_addr = 32'h0200_0000;
  localparam addr_t clint_top_addr = 32'h0201_0000;

  localparam int tim_depth_words = 1024;

  // clint register offsets within its region
  localparam addr_t clint_msip_offset = 32'h0000_0000;
  localparam addr_t clint_mtimecmp_lo_offset = 32'h0000_4000;
  localparam addr_t clint_mtimecmp_hi_offset = 32'h0000_4004;
  localparam addr_t clint_mtime_lo_offset = 32'h0000_bff8;
  localparam addr_t clint_mtime_hi_offset = 32'h0000_bffc;

  // clocks per mtime step
  localparam int rtc_divider = 4;
  localparam int rtc_count_bits = $clog2(rtc_divider);

endpackage

// ==== logic/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if;

  logic valid;
  soc_pkg::addr_t addr;
  soc_pkg::data_t wdata;
  soc_pkg::strb_t wstrb;
  soc_pkg::data_t rdata;
  logic ready;

  modport requester (
    output valid, addr, wdata, wstrb,
    input rdata, ready
  );

  modport responder (
    input valid, addr, wdata, wstrb,
    output rdata, ready
  );

endinterface

// ==== logic/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder (
  input logic clock,
  mem_bus_if.responder req,
  mem_bus_if.requester tim0,
  mem_bus_if.requester tim1,
  mem_bus_if.requester clint
);

  logic hit_tim0;
  logic hit_tim1;
  logic hit_clint;
  soc_pkg::addr_t base;

  assign hit_tim0 = req.addr >= soc_pkg::tim0_base_addr &&
                    req.addr < soc_pkg::tim0_top_addr;
  assign hit_tim1 = req.addr >= soc_pkg::tim1_base_addr &&
                    req.addr < soc_pkg::tim1_top_addr;
  assign hit_clint = req.addr >= soc_pkg::clint_base_addr &&
                     req.addr < soc_pkg::clint_top_addr;

  always_comb begin
    base = '0;
    if (hit_tim0) begin
      base = soc_pkg::tim0_base_addr;
    end else if (hit_tim1) begin
      base = soc_pkg::tim1_base_addr;
    end else if (hit_clint) begin
      base = soc_pkg::clint_base_addr;
    end
  end

  // unmapped addresses raise no valid, so they never see ready
  assign tim0.valid = req.valid && hit_tim0;
  assign tim1.valid = req.valid && hit_tim1;
  assign clint.valid = req.valid && hit_clint;

  assign tim0.addr = req.addr - base;
  assign tim1.addr = req.addr - base;
  assign clint.addr = req.addr - base;

  assign tim0.wdata = req.wdata;
  assign tim1.wdata = req.wdata;
  assign clint.wdata = req.wdata;

  assign tim0.wstrb = req.wstrb;
  assign tim1.wstrb = req.wstrb;
  assign clint.wstrb = req.wstrb;

  assign req.ready = tim0.ready | tim1.ready | clint.ready;

  always_comb begin
    if (tim0.ready) begin
      req.rdata = tim0.rdata;
    end else if (tim1.ready) begin
      req.rdata = tim1.rdata;
    end else begin
      req.rdata = clint.ready ? clint.rdata : '0;
    end
  end

  // one access outstanding per port, so at most one target answers
  single_response: assert property (@(posedge clock)
    $onehot0({tim0.ready, tim1.ready, clint.ready}));

endmodule

// ==== logic/port_arbiter.sv ====
`timescale 1ns/1ps

module port_arbiter (
  input logic clock,
  input logic reset,
  mem_bus_if.responder inst,
  mem_bus_if.responder data,
  mem_bus_if.requester target
);

  soc_pkg::grant_e state;
  soc_pkg::grant_e grant;

  // from idle the grant is given in the same cycle, data port first
  always_comb begin
    grant = state;
    if (state == soc_pkg::grant_none) begin
      if (data.valid) begin
        grant = soc_pkg::grant_data;
      end else if (inst.valid) begin
        grant = soc_pkg::grant_inst;
      end
    end
  end

  // hold the grant until the target answers
  always_ff @(posedge clock) begin
    if (reset || target.ready) begin
      state <= soc_pkg::grant_none;
    end else begin
      state <= grant;
    end
  end

  always_comb begin
    if (grant == soc_pkg::grant_inst) begin
      target.valid = inst.valid;
      target.addr = inst.addr;
      target.wdata = inst.wdata;
      target.wstrb = inst.wstrb;
    end else begin
      target.valid = data.valid && grant == soc_pkg::grant_data;
      target.addr = data.addr;
      target.wdata = data.wdata;
      target.wstrb = data.wstrb;
    end
  end

  // the losing side sees no ready and keeps waiting
  assign inst.ready = target.ready && state == soc_pkg::grant_inst;
  assign data.ready = target.ready && state == soc_pkg::grant_data;
  assign inst.rdata = target.rdata;
  assign data.rdata = target.rdata;

  granted_valid_held: assert property (@(posedge clock) disable iff (reset)
    state != soc_pkg::grant_none |->
      (state == soc_pkg::grant_inst ? inst.valid : data.valid));

  // a target answer only arrives while one side holds the grant
  ready_to_granted: assert property (@(posedge clock) disable iff (reset)
    target.ready |-> state != soc_pkg::grant_none);

endmodule

// ==== logic/tim.sv ====
`timescale 1ns/1ps

module tim (
  input logic clock,
  input logic reset,
  mem_bus_if.responder bus
);

  soc_pkg::data_t mem [soc_pkg::tim_depth_words];
  soc_pkg::data_t rdata_r;
  logic [9:0] index;
  logic ready_r;
  logic access;

  // word index, byte offset bits are dropped
  assign index = bus.addr[11:2];

  // valid in the ready cycle belongs to the finished access
  assign access = bus.valid && !ready_r;

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_r <= 1'b0;
    end else begin
      ready_r <= access;
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      for (int i = 0; i < $bits(soc_pkg::strb_t); i++) begin
        if (bus.wstrb[i]) begin
          mem[index][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
      rdata_r <= mem[index];
    end
  end

  assign bus.ready = ready_r;
  assign bus.rdata = rdata_r;

  ready_one_cycle: assert property (@(posedge clock) disable iff (reset)
    bus.ready |=> !bus.ready);

endmodule

// ==== logic/clint_regs.sv ====
`timescale 1ns/1ps

module clint_regs (
  input logic clock,
  input logic reset,
  mem_bus_if.responder bus,
  input soc_pkg::mtime_t mtime,
  output logic mtime_load,
  output logic mtime_load_hi,
  output soc_pkg::data_t mtime_wdata,
  output soc_pkg::mtime_t mtimecmp,
  output logic msip
);

  logic ready_r;
  logic access;
  logic write;
  soc_pkg::data_t rdata_r;

  assign access = bus.valid && !ready_r;
  assign write = access && bus.wstrb != '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_r <= 1'b0;
      msip <= 1'b0;
      mtimecmp <= '1;
    end else begin
      ready_r <= access;
      if (write) begin
        case (bus.addr)
          soc_pkg::clint_msip_offset: msip <= bus.wdata[0];
          soc_pkg::clint_mtimecmp_lo_offset: mtimecmp[31:0] <= bus.wdata;
          soc_pkg::clint_mtimecmp_hi_offset: mtimecmp[63:32] <= bus.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      case (bus.addr)
        soc_pkg::clint_msip_offset: rdata_r <= soc_pkg::data_t'(msip);
        soc_pkg::clint_mtimecmp_lo_offset: rdata_r <= mtimecmp[31:0];
        soc_pkg::clint_mtimecmp_hi_offset: rdata_r <= mtimecmp[63:32];
        soc_pkg::clint_mtime_lo_offset: rdata_r <= mtime[31:0];
        soc_pkg::clint_mtime_hi_offset: rdata_r <= mtime[63:32];
        default: rdata_r <= '0;
      endcase
    end
  end

  // mtime itself lives in the timer, writes are passed on as a load pulse
  assign mtime_load = write && (bus.addr == soc_pkg::clint_mtime_lo_offset ||
                                bus.addr == soc_pkg::clint_mtime_hi_offset);
  assign mtime_load_hi = bus.addr == soc_pkg::clint_mtime_hi_offset;
  assign mtime_wdata = bus.wdata;

  assign bus.ready = ready_r;
  assign bus.rdata = rdata_r;

endmodule

// ==== logic/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer (
  input logic clock,
  input logic reset,
  input logic mtime_load,
  input logic mtime_load_hi,
  input soc_pkg::data_t mtime_wdata,
  input soc_pkg::mtime_t mtimecmp,
  output soc_pkg::mtime_t mtime,
  output logic mtip
);

  logic [soc_pkg::rtc_count_bits-1:0] prescale;
  logic tick;

  assign tick = prescale == soc_pkg::rtc_count_bits'(soc_pkg::rtc_divider - 1);

  always_ff @(posedge clock) begin
    if (reset) begin
      prescale <= '0;
      mtime <= '0;
      mtip <= 1'b0;
    end else begin
      prescale <= tick ? '0 : prescale + 1'b1;
      // a bus load wins over the count step
      if (mtime_load) begin
        if (mtime_load_hi) begin
          mtime[63:32] <= mtime_wdata;
        end else begin
          mtime[31:0] <= mtime_wdata;
        end
      end else if (tick) begin
        mtime <= mtime + 1'b1;
      end
      mtip <= mtime >= mtimecmp;
    end
  end

endmodule

// ==== logic/soc_fabric.sv ====
`timescale 1ns/1ps

module soc_fabric (
  input logic clock,
  input logic reset,
  input logic imem_valid,
  input soc_pkg::addr_t imem_addr,
  input soc_pkg::data_t imem_wdata,
  input soc_pkg::strb_t imem_wstrb,
  output soc_pkg::data_t imem_rdata,
  output logic imem_ready,
  input logic dmem_valid,
  input soc_pkg::addr_t dmem_addr,
  input soc_pkg::data_t dmem_wdata,
  input soc_pkg::strb_t dmem_wstrb,
  output soc_pkg::data_t dmem_rdata,
  output logic dmem_ready,
  output logic msip,
  output logic mtip
);

  mem_bus_if imem_bus ();
  mem_bus_if dmem_bus ();
  mem_bus_if inst_tim0_bus ();
  mem_bus_if inst_tim1_bus ();
  mem_bus_if inst_clint_bus ();
  mem_bus_if data_tim0_bus ();
  mem_bus_if data_tim1_bus ();
  mem_bus_if data_clint_bus ();
  mem_bus_if tim0_bus ();
  mem_bus_if tim1_bus ();
  mem_bus_if clint_bus ();

  soc_pkg::mtime_t mtime;
  soc_pkg::mtime_t mtimecmp;
  soc_pkg::data_t mtime_wdata;
  logic mtime_load;
  logic mtime_load_hi;

  assign imem_bus.valid = imem_valid;
  assign imem_bus.addr = imem_addr;
  assign imem_bus.wdata = imem_wdata;
  assign imem_bus.wstrb = imem_wstrb;
  assign imem_rdata = imem_bus.rdata;
  assign imem_ready = imem_bus.ready;

  assign dmem_bus.valid = dmem_valid;
  assign dmem_bus.addr = dmem_addr;
  assign dmem_bus.wdata = dmem_wdata;
  assign dmem_bus.wstrb = dmem_wstrb;
  assign dmem_rdata = dmem_bus.rdata;
  assign dmem_ready = dmem_bus.ready;

  addr_decoder inst_decoder (
    .clock(clock),
    .req(imem_bus),
    .tim0(inst_tim0_bus),
    .tim1(inst_tim1_bus),
    .clint(inst_clint_bus)
  );

  addr_decoder data_decoder (
    .clock(clock),
    .req(dmem_bus),
    .tim0(data_tim0_bus),
    .tim1(data_tim1_bus),
    .clint(data_clint_bus)
  );

  port_arbiter tim0_arbiter (
    .clock(clock),
    .reset(reset),
    .inst(inst_tim0_bus),
    .data(data_tim0_bus),
    .target(tim0_bus)
  );

  port_arbiter tim1_arbiter (
    .clock(clock),
    .reset(reset),
    .inst(inst_tim1_bus),
    .data(data_tim1_bus),
    .target(tim1_bus)
  );

  port_arbiter clint_arbiter (
    .clock(clock),
    .reset(reset),
    .inst(inst_clint_bus),
    .data(data_clint_bus),
    .target(clint_bus)
  );

  tim tim0 (
    .clock(clock),
    .reset(reset),
    .bus(tim0_bus)
  );

  tim tim1 (
    .clock(clock),
    .reset(reset),
    .bus(tim1_bus)
  );

  clint_regs clint (
    .clock(clock),
    .reset(reset),
    .bus(clint_bus),
    .mtime(mtime),
    .mtime_load(mtime_load),
    .mtime_load_hi(mtime_load_hi),
    .mtime_wdata(mtime_wdata),
    .mtimecmp(mtimecmp),
    .msip(msip)
  );

  clint_timer rtc_timer (
    .clock(clock),
    .reset(reset),
    .mtime_load(mtime_load),
    .mtime_load_hi(mtime_load_hi),
    .mtime_wdata(mtime_wdata),
    .mtimecmp(mtimecmp),
    .mtime(mtime),
    .mtip(mtip)
  );

endmodule

// ==== bench/soc_fabric_tb.sv ====
`timescale 1ns/1ps

module soc_fabric_tb;

  localparam logic port_inst = 1'b0;
  localparam logic port_data = 1'b1;
  // all tests together run a few hundred cycles, the rest is margin
  localparam int timeout_cycles = 2000;

  logic clock;
  logic reset;
  logic imem_valid;
  soc_pkg::addr_t imem_addr;
  soc_pkg::data_t imem_wdata;
  soc_pkg::strb_t imem_wstrb;
  soc_pkg::data_t imem_rdata;
  logic imem_ready;
  logic dmem_valid;
  soc_pkg::addr_t dmem_addr;
  soc_pkg::data_t dmem_wdata;
  soc_pkg::strb_t dmem_wstrb;
  soc_pkg::data_t dmem_rdata;
  logic dmem_ready;
  logic msip;
  logic mtip;
  integer seed;
  int cycle_count = 0;

  soc_fabric i_soc_fabric (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      abort_run("timeout, the tests did not finish within the cycle limit");
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_data(input string name, input soc_pkg::data_t expected,
                            input soc_pkg::data_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  task automatic check_time(input string name, input soc_pkg::mtime_t expected,
                            input soc_pkg::mtime_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // old word with only the strobed byte lanes taken from the new word
  function automatic soc_pkg::data_t merge_lanes(input soc_pkg::data_t old_word,
                                                 input soc_pkg::data_t new_word,
                                                 input soc_pkg::strb_t strb);
    soc_pkg::data_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  // starts and ends 1 ns after a rising edge
  task automatic bus_access(input logic use_data, input soc_pkg::addr_t addr,
                            input soc_pkg::data_t wdata, input soc_pkg::strb_t wstrb,
                            output soc_pkg::data_t rdata);
    int waited;
    if (use_data) begin
      dmem_addr = addr;
      dmem_wdata = wdata;
      dmem_wstrb = wstrb;
      dmem_valid = 1'b1;
    end else begin
      imem_addr = addr;
      imem_wdata = wdata;
      imem_wstrb = wstrb;
      imem_valid = 1'b1;
    end
    waited = 0;
    @(negedge clock);
    while (!(use_data ? dmem_ready : imem_ready)) begin
      waited++;
      if (waited >= 10) begin
        abort_run($sformatf("no ready within 10 cycles for address %h", addr));
      end
      @(negedge clock);
    end
    rdata = use_data ? dmem_rdata : imem_rdata;
    @(posedge clock);
    #1;
    if (use_data) begin
      dmem_valid = 1'b0;
    end else begin
      imem_valid = 1'b0;
    end
  endtask

  task automatic bus_write(input logic use_data, input soc_pkg::addr_t addr,
                           input soc_pkg::data_t wdata, input soc_pkg::strb_t wstrb);
    soc_pkg::data_t unused;
    bus_access(use_data, addr, wdata, wstrb, unused);
  endtask

  task automatic bus_read(input logic use_data, input soc_pkg::addr_t addr,
                          output soc_pkg::data_t rdata);
    bus_access(use_data, addr, '0, 4'h0, rdata);
  endtask

  task automatic test_reset_and_regions();
    soc_pkg::data_t words0 [4];
    soc_pkg::data_t words1 [4];
    soc_pkg::addr_t offset;
    soc_pkg::data_t value;
    check_bit("reset msip", 1'b0, msip);
    check_bit("reset mtip", 1'b0, mtip);
    check_bit("reset imem_ready", 1'b0, imem_ready);
    check_bit("reset dmem_ready", 1'b0, dmem_ready);
    // last offset is the top word of each region
    for (int k = 0; k < 4; k++) begin
      offset = k * 32'h554;
      words0[k] = $random(seed);
      words1[k] = $random(seed);
      bus_write(port_data, soc_pkg::tim0_base_addr + offset, words0[k], 4'hf);
      bus_write(port_data, soc_pkg::tim1_base_addr + offset, words1[k], 4'hf);
    end
    for (int k = 0; k < 4; k++) begin
      offset = k * 32'h554;
      for (int p = 0; p < 2; p++) begin
        bus_read(logic'(p), soc_pkg::tim0_base_addr + offset, value);
        check_data("tim0 readback", words0[k], value);
        bus_read(logic'(p), soc_pkg::tim1_base_addr + offset, value);
        check_data("tim1 readback", words1[k], value);
      end
    end
  endtask

  task automatic test_partial_writes();
    soc_pkg::strb_t strobes [4];
    soc_pkg::addr_t addr;
    soc_pkg::data_t expected;
    soc_pkg::data_t fresh;
    soc_pkg::data_t value;
    strobes = '{4'b0001, 4'b0100, 4'b0011, 4'b1100};
    addr = soc_pkg::tim1_base_addr + 32'h100;
    expected = $random(seed);
    bus_write(port_data, addr, expected, 4'hf);
    foreach (strobes[i]) begin
      fresh = $random(seed);
      bus_write(port_data, addr, fresh, strobes[i]);
      expected = merge_lanes(expected, fresh, strobes[i]);
      bus_read(logic'(i % 2), addr, value);
      check_data($sformatf("strobe %b", strobes[i]), expected, value);
    end
  endtask

  task automatic test_contention();
    soc_pkg::addr_t addr;
    soc_pkg::data_t word;
    soc_pkg::data_t inst_word;
    int n;
    int data_at;
    int inst_at;
    addr = soc_pkg::tim0_base_addr + 32'h20;
    word = $random(seed);
    dmem_addr = addr;
    dmem_wdata = word;
    dmem_wstrb = 4'hf;
    dmem_valid = 1'b1;
    imem_addr = addr;
    imem_wstrb = 4'h0;
    imem_valid = 1'b1;
    n = 0;
    data_at = 0;
    inst_at = 0;
    while (data_at == 0 || inst_at == 0) begin
      @(negedge clock);
      n++;
      if (n > 10) begin
        abort_run("a port got no ready while both ports hit the same TIM");
      end
      if (dmem_ready && data_at == 0) begin
        data_at = n;
      end
      if (imem_ready && inst_at == 0) begin
        inst_at = n;
        inst_word = imem_rdata;
      end
      @(posedge clock);
      #1;
      if (data_at != 0) begin
        dmem_valid = 1'b0;
      end
      if (inst_at != 0) begin
        imem_valid = 1'b0;
      end
    end
    if (data_at >= inst_at) begin
      abort_run("instruction ready did not come after data ready under contention");
    end
    check_data("contended instruction read", word, inst_word);
  endtask

  task automatic test_msip();
    soc_pkg::data_t value;
    bus_write(port_data, soc_pkg::clint_base_addr + soc_pkg::clint_msip_offset, 32'h1, 4'hf);
    check_bit("msip output set", 1'b1, msip);
    bus_read(port_inst, soc_pkg::clint_base_addr + soc_pkg::clint_msip_offset, value);
    check_data("msip register set", 32'h1, value);
    bus_write(port_data, soc_pkg::clint_base_addr + soc_pkg::clint_msip_offset, 32'h0, 4'hf);
    check_bit("msip output clear", 1'b0, msip);
    bus_read(port_data, soc_pkg::clint_base_addr + soc_pkg::clint_msip_offset, value);
    check_data("msip register clear", 32'h0, value);
  endtask

  task automatic test_timer();
    soc_pkg::data_t lo;
    soc_pkg::data_t hi;
    int waited;
    bus_write(port_data, soc_pkg::clint_base_addr + soc_pkg::clint_mtimecmp_hi_offset, 0, 4'hf);
    bus_write(port_data, soc_pkg::clint_base_addr + soc_pkg::clint_mtimecmp_lo_offset, 20, 4'hf);
    bus_write(port_data, soc_pkg::clint_base_addr + soc_pkg::clint_mtime_lo_offset, 0, 4'hf);
    bus_write(port_data, soc_pkg::clint_base_addr + soc_pkg::clint_mtime_hi_offset, 0, 4'hf);
    check_bit("mtip after mtime load", 1'b0, mtip);
    waited = 0;
    @(negedge clock);
    while (!mtip) begin
      waited++;
      if (waited > 20 * soc_pkg::rtc_divider + 10) begin
        abort_run("mtip did not rise once mtime reached mtimecmp");
      end
      @(negedge clock);
    end
    @(posedge clock);
    #1;
    bus_read(port_data, soc_pkg::clint_base_addr + soc_pkg::clint_mtime_lo_offset, lo);
    bus_read(port_data, soc_pkg::clint_base_addr + soc_pkg::clint_mtime_hi_offset, hi);
    check_bit("mtime at least compare", 1'b1, {hi, lo} >= 64'd20);
    bus_read(port_inst, soc_pkg::clint_base_addr + soc_pkg::clint_mtimecmp_lo_offset, lo);
    bus_read(port_inst, soc_pkg::clint_base_addr + soc_pkg::clint_mtimecmp_hi_offset, hi);
    check_time("mtimecmp readback", 64'd20, {hi, lo});
    bus_write(port_data, soc_pkg::clint_base_addr + soc_pkg::clint_mtimecmp_lo_offset, '1, 4'hf);
    bus_write(port_data, soc_pkg::clint_base_addr + soc_pkg::clint_mtimecmp_hi_offset, '1, 4'hf);
    check_bit("mtip after compare reset", 1'b0, mtip);
  endtask

  task automatic test_unmapped();
    soc_pkg::addr_t addr;
    soc_pkg::data_t word;
    soc_pkg::data_t value;
    dmem_addr = 32'h3000_0000;
    dmem_wstrb = 4'h0;
    dmem_valid = 1'b1;
    repeat (20) begin
      @(negedge clock);
      if (dmem_ready) begin
        abort_run("an unmapped address got a ready");
      end
    end
    @(posedge clock);
    #1;
    dmem_valid = 1'b0;
    addr = soc_pkg::tim1_base_addr + 32'h80;
    word = $random(seed);
    bus_write(port_data, addr, word, 4'hf);
    bus_read(port_inst, addr, value);
    check_data("access after unmapped", word, value);
  endtask

  initial begin
    seed = 32'hcab99d94;
    reset = 1'b1;
    imem_valid = 1'b0;
    imem_addr = '0;
    imem_wdata = '0;
    imem_wstrb = '0;
    dmem_valid = 1'b0;
    dmem_addr = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    test_reset_and_regions();
    test_partial_writes();
    test_contention();
    test_msip();
    test_timer();
    test_unmapped();
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== src.f ====
logic/soc_pkg.sv
logic/mem_bus_if.sv
logic/addr_decoder.sv
logic/port_arbiter.sv
logic/tim.sv
logic/clint_regs.sv
logic/clint_timer.sv
logic/soc_fabric.sv
bench/soc_fabric_tb.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := soc_fabric_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
